// File: hdl/ipu_pkg.sv
package ipu_pkg;

  // ------------------------------------------------------------
  // Widths and cluster configuration
  // ------------------------------------------------------------
  localparam int DataWidth    = 32;
  localparam int IdWidth      = 5;
  localparam int NumLanes     = 4;
  localparam int LaneIdxWidth = $clog2(NumLanes);

  // Cut registers on the offload paths
  localparam bit RegisterReq  = 1'b1;
  localparam bit RegisterResp = 1'b1;

  // Codes 4 to 7 are unused and answered with an error
  typedef enum logic [2:0] {
    OpMul    = 3'd0,
    OpMulh   = 3'd1,
    OpMulhsu = 3'd2,
    OpMulhu  = 3'd3
  } ipu_op_e;

  // Packed request {id, op, a, b} and response {id, error, data}
  localparam int ReqWidth  = IdWidth + $bits(ipu_op_e) + 2 * DataWidth;
  localparam int RespWidth = IdWidth + 1 + DataWidth;

  // Next lane index, wrapping for any lane count
  function automatic logic [LaneIdxWidth-1:0] rr_next(input logic [LaneIdxWidth-1:0] idx);
    return (idx == LaneIdxWidth'(NumLanes - 1)) ? '0 : idx + 1'b1;
  endfunction

  // First set bit of req, searching upward from ptr
  function automatic logic [LaneIdxWidth-1:0] rr_pick(input logic [NumLanes-1:0] req,
                                                      input logic [LaneIdxWidth-1:0] ptr);
    logic [LaneIdxWidth-1:0] idx;
    logic [LaneIdxWidth-1:0] pick;
    logic                    found;
    idx   = ptr;
    pick  = ptr;
    found = 1'b0;
    for (int i = 0; i < NumLanes; i++) begin
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
      idx = rr_next(idx);
    end
    return pick;
  endfunction

endpackage

// File: hdl/spill_register.sv
`timescale 1ns/10ps

module spill_register import ipu_pkg::*; #(
  parameter int Width  = ReqWidth,
  parameter bit Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    logic             a_full_q;
    logic             b_full_q;
    logic [Width-1:0] a_data_q;
    logic [Width-1:0] b_data_q;
    logic             a_fill;
    logic             a_drain;
    logic             b_fill;
    logic             b_drain;

    // A takes new beats, B catches A when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B holds the older beat when both are full
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
    assign ready_o = !a_full_q || !b_full_q;
  end

endmodule

// File: hdl/offload_dispatch.sv
`timescale 1ns/10ps

module offload_dispatch import ipu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Request from the cut register
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [IdWidth-1:0]   req_id_i,
  input  ipu_op_e              req_op_i,
  input  logic [DataWidth-1:0] req_arga_i,
  input  logic [DataWidth-1:0] req_argb_i,
  // Per-lane request bus, payload shared
  output logic [NumLanes-1:0]  lane_valid_o,
  input  logic [NumLanes-1:0]  lane_ready_i,
  output logic [IdWidth-1:0]   lane_id_o,
  output ipu_op_e              lane_op_o,
  output logic [DataWidth-1:0] lane_arga_o,
  output logic [DataWidth-1:0] lane_argb_o
);

  logic [LaneIdxWidth-1:0] ptr_q;
  logic [LaneIdxWidth-1:0] sel;
  logic                    any_ready;

  assign any_ready = |lane_ready_i;
  assign sel       = rr_pick(lane_ready_i, ptr_q);

  // Only the chosen ready lane sees valid
  always_comb begin
    lane_valid_o      = '0;
    lane_valid_o[sel] = req_valid_i && any_ready;
  end

  assign req_ready_o = any_ready;

  assign lane_id_o   = req_id_i;
  assign lane_op_o   = req_op_i;
  assign lane_arga_o = req_arga_i;
  assign lane_argb_o = req_argb_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (req_valid_i && any_ready) begin
      ptr_q <= rr_next(sel);
    end
  end

endmodule

// File: hdl/ipu_lane.sv
`timescale 1ns/10ps

module ipu_lane import ipu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  logic [IdWidth-1:0]   req_id_i,
  input  ipu_op_e              req_op_i,
  input  logic [DataWidth-1:0] req_arga_i,
  input  logic [DataWidth-1:0] req_argb_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output logic [IdWidth-1:0]   resp_id_o,
  output logic                 resp_error_o,
  output logic [DataWidth-1:0] resp_data_o
);

  // ------------------------------------------------------------
  // Stage 1: operand sign extension
  // ------------------------------------------------------------
  logic                        s1_valid_q;
  logic [IdWidth-1:0]          s1_id_q;
  ipu_op_e                     s1_op_q;
  logic signed [DataWidth:0]   s1_a_q;
  logic signed [DataWidth:0]   s1_b_q;
  logic                        s1_ready;
  logic                        a_signed;
  logic                        b_signed;

  // ------------------------------------------------------------
  // Stage 2: product and half select
  // ------------------------------------------------------------
  logic                        s2_valid_q;
  logic [IdWidth-1:0]          s2_id_q;
  logic                        s2_error_q;
  logic [DataWidth-1:0]        s2_data_q;
  logic                        s2_ready;
  logic signed [2*DataWidth+1:0] prod;
  logic                        res_error;
  logic [DataWidth-1:0]        res_data;

  assign a_signed = (req_op_i == OpMulh) || (req_op_i == OpMulhsu);
  assign b_signed = (req_op_i == OpMulh);

  assign s2_ready    = !s2_valid_q || resp_ready_i;
  assign s1_ready    = !s1_valid_q || s2_ready;
  assign req_ready_o = s1_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= req_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && s1_ready) begin
      s1_id_q <= req_id_i;
      s1_op_q <= req_op_i;
      s1_a_q  <= {a_signed & req_arga_i[DataWidth-1], req_arga_i};
      s1_b_q  <= {b_signed & req_argb_i[DataWidth-1], req_argb_i};
    end
  end

  assign prod = s1_a_q * s1_b_q;

  always_comb begin
    res_error = 1'b0;
    res_data  = '0;
    case (s1_op_q)
      OpMul:                    res_data = prod[DataWidth-1:0];
      OpMulh, OpMulhsu, OpMulhu: res_data = prod[2*DataWidth-1:DataWidth];
      default:                  res_error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q && s2_ready) begin
      s2_id_q    <= s1_id_q;
      s2_error_q <= res_error;
      s2_data_q  <= res_data;
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_id_o    = s2_id_q;
  assign resp_error_o = s2_error_q;
  assign resp_data_o  = s2_data_q;

endmodule

// File: hdl/offload_collect.sv
`timescale 1ns/10ps

module offload_collect import ipu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Per-lane responses
  input  logic [NumLanes-1:0]  lane_valid_i,
  output logic [NumLanes-1:0]  lane_ready_o,
  input  logic [IdWidth-1:0]   lane_id_i    [NumLanes],
  input  logic                 lane_error_i [NumLanes],
  input  logic [DataWidth-1:0] lane_data_i  [NumLanes],
  // Merged response
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output logic [IdWidth-1:0]   resp_id_o,
  output logic                 resp_error_o,
  output logic [DataWidth-1:0] resp_data_o
);

  logic [LaneIdxWidth-1:0] ptr_q;
  logic [LaneIdxWidth-1:0] grant;

  assign grant        = rr_pick(lane_valid_i, ptr_q);
  assign resp_valid_o = |lane_valid_i;

  // Ready goes back to the granted lane alone
  always_comb begin
    lane_ready_o        = '0;
    lane_ready_o[grant] = resp_ready_i && resp_valid_o;
  end

  assign resp_id_o    = lane_id_i[grant];
  assign resp_error_o = lane_error_i[grant];
  assign resp_data_o  = lane_data_i[grant];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (resp_valid_o && resp_ready_i) begin
      ptr_q <= rr_next(grant);
    end
  end

endmodule

// File: hdl/ipu_cluster.sv
`timescale 1ns/10ps

module ipu_cluster import ipu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Offload request
  input  logic [IdWidth-1:0]   acc_qid_i,
  input  ipu_op_e              acc_qop_i,
  input  logic [DataWidth-1:0] acc_qarga_i,
  input  logic [DataWidth-1:0] acc_qargb_i,
  input  logic                 acc_qvalid_i,
  output logic                 acc_qready_o,
  // Offload response
  output logic [DataWidth-1:0] acc_pdata_o,
  output logic [IdWidth-1:0]   acc_pid_o,
  output logic                 acc_perror_o,
  output logic                 acc_pvalid_o,
  input  logic                 acc_pready_i
);

  logic [ReqWidth-1:0]  req_q;
  logic                 req_q_valid;
  logic                 req_q_ready;
  logic [RespWidth-1:0] resp_d;
  logic                 resp_d_valid;
  logic                 resp_d_ready;

  logic [NumLanes-1:0]  lane_req_valid;
  logic [NumLanes-1:0]  lane_req_ready;
  logic [IdWidth-1:0]   lane_req_id;
  ipu_op_e              lane_req_op;
  logic [DataWidth-1:0] lane_req_arga;
  logic [DataWidth-1:0] lane_req_argb;

  logic [NumLanes-1:0]  lane_resp_valid;
  logic [NumLanes-1:0]  lane_resp_ready;
  logic [IdWidth-1:0]   lane_resp_id    [NumLanes];
  logic                 lane_resp_error [NumLanes];
  logic [DataWidth-1:0] lane_resp_data  [NumLanes];

  logic [IdWidth-1:0]   coll_id;
  logic                 coll_error;
  logic [DataWidth-1:0] coll_data;

  // Cut request path
  spill_register #(
    .Width  ( ReqWidth     ),
    .Bypass ( !RegisterReq )
  ) i_spill_register_req (
    .clk_i   ( clk_i                                              ),
    .rst_i   ( rst_i                                              ),
    .valid_i ( acc_qvalid_i                                       ),
    .ready_o ( acc_qready_o                                       ),
    .data_i  ( {acc_qid_i, acc_qop_i, acc_qarga_i, acc_qargb_i}  ),
    .valid_o ( req_q_valid                                        ),
    .ready_i ( req_q_ready                                        ),
    .data_o  ( req_q                                              )
  );

  offload_dispatch i_offload_dispatch (
    .clk_i        ( clk_i                                                  ),
    .rst_i        ( rst_i                                                  ),
    .req_valid_i  ( req_q_valid                                            ),
    .req_ready_o  ( req_q_ready                                            ),
    .req_id_i     ( req_q[ReqWidth-1 -: IdWidth]                           ),
    .req_op_i     ( ipu_op_e'(req_q[2*DataWidth +: $bits(ipu_op_e)])       ),
    .req_arga_i   ( req_q[DataWidth +: DataWidth]                          ),
    .req_argb_i   ( req_q[DataWidth-1:0]                                   ),
    .lane_valid_o ( lane_req_valid                                         ),
    .lane_ready_i ( lane_req_ready                                         ),
    .lane_id_o    ( lane_req_id                                            ),
    .lane_op_o    ( lane_req_op                                            ),
    .lane_arga_o  ( lane_req_arga                                          ),
    .lane_argb_o  ( lane_req_argb                                          )
  );

  for (genvar k = 0; k < NumLanes; k++) begin : gen_lane
    ipu_lane i_ipu_lane (
      .clk_i        ( clk_i              ),
      .rst_i        ( rst_i              ),
      .req_valid_i  ( lane_req_valid[k]  ),
      .req_ready_o  ( lane_req_ready[k]  ),
      .req_id_i     ( lane_req_id        ),
      .req_op_i     ( lane_req_op        ),
      .req_arga_i   ( lane_req_arga      ),
      .req_argb_i   ( lane_req_argb      ),
      .resp_valid_o ( lane_resp_valid[k] ),
      .resp_ready_i ( lane_resp_ready[k] ),
      .resp_id_o    ( lane_resp_id[k]    ),
      .resp_error_o ( lane_resp_error[k] ),
      .resp_data_o  ( lane_resp_data[k]  )
    );
  end

  offload_collect i_offload_collect (
    .clk_i        ( clk_i           ),
    .rst_i        ( rst_i           ),
    .lane_valid_i ( lane_resp_valid ),
    .lane_ready_o ( lane_resp_ready ),
    .lane_id_i    ( lane_resp_id    ),
    .lane_error_i ( lane_resp_error ),
    .lane_data_i  ( lane_resp_data  ),
    .resp_valid_o ( resp_d_valid    ),
    .resp_ready_i ( resp_d_ready    ),
    .resp_id_o    ( coll_id         ),
    .resp_error_o ( coll_error      ),
    .resp_data_o  ( coll_data       )
  );

  assign resp_d = {coll_id, coll_error, coll_data};

  // Cut response path
  spill_register #(
    .Width  ( RespWidth     ),
    .Bypass ( !RegisterResp )
  ) i_spill_register_resp (
    .clk_i   ( clk_i                                  ),
    .rst_i   ( rst_i                                  ),
    .valid_i ( resp_d_valid                           ),
    .ready_o ( resp_d_ready                           ),
    .data_i  ( resp_d                                 ),
    .valid_o ( acc_pvalid_o                           ),
    .ready_i ( acc_pready_i                           ),
    .data_o  ( {acc_pid_o, acc_perror_o, acc_pdata_o} )
  );

endmodule

// File: verif/ipu_scoreboard.sv
`timescale 1ns/10ps

module ipu_scoreboard import ipu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Request port as seen by the DUT
  input  logic                  qvalid_i,
  input  logic                  qready_i,
  input  logic [IdWidth-1:0]    qid_i,
  input  logic [2:0]            qop_i,
  input  logic [DataWidth-1:0]  qarga_i,
  input  logic [DataWidth-1:0]  qargb_i,
  // Response port as seen by the DUT
  input  logic                  pvalid_i,
  input  logic                  pready_i,
  input  logic [IdWidth-1:0]    pid_i,
  input  logic                  perror_i,
  input  logic [DataWidth-1:0]  pdata_i,
  output logic [2**IdWidth-1:0] pending_o,
  output int                    error_count_o,
  output int                    resp_count_o
);

  logic [2:0]           op_tab [2**IdWidth];
  logic [DataWidth-1:0] a_tab  [2**IdWidth];
  logic [DataWidth-1:0] b_tab  [2**IdWidth];
  logic                 hold_q;
  logic [RespWidth-1:0] held_q;

  // Product rules, computed modulo 2**(2*DataWidth)
  function automatic logic [DataWidth-1:0] expected_data(input logic [2:0] op,
                                                         input logic [DataWidth-1:0] a,
                                                         input logic [DataWidth-1:0] b);
    logic [2*DataWidth-1:0] sa;
    logic [2*DataWidth-1:0] sb;
    logic [2*DataWidth-1:0] prod;
    sa = {{DataWidth{a[DataWidth-1]}}, a};
    sb = {{DataWidth{b[DataWidth-1]}}, b};
    case (op)
      OpMul:    prod = {{DataWidth{1'b0}}, a} * {{DataWidth{1'b0}}, b};
      OpMulh:   prod = sa * sb;
      OpMulhsu: prod = sa * {{DataWidth{1'b0}}, b};
      OpMulhu:  prod = {{DataWidth{1'b0}}, a} * {{DataWidth{1'b0}}, b};
      default:  return '0;
    endcase
    return (op == OpMul) ? prod[DataWidth-1:0] : prod[2*DataWidth-1:DataWidth];
  endfunction

  task automatic check_response();
    logic                 exp_err;
    logic [DataWidth-1:0] exp_data;
    resp_count_o++;
    assert (pending_o[pid_i]) else begin
      $display("%s: response with id %0d that is not outstanding", ipu_cluster_tb.test_name,
               pid_i);
      error_count_o++;
    end
    if (pending_o[pid_i]) begin
      exp_err  = !(op_tab[pid_i] inside {OpMul, OpMulh, OpMulhsu, OpMulhu});
      exp_data = expected_data(op_tab[pid_i], a_tab[pid_i], b_tab[pid_i]);
      assert (perror_i == exp_err) else begin
        $display("mismatch %s id %0d error: expected %0b actual %0b", ipu_cluster_tb.test_name,
                 pid_i, exp_err, perror_i);
        error_count_o++;
      end
      assert (pdata_i == exp_data) else begin
        $display("mismatch %s id %0d data: expected %h actual %h", ipu_cluster_tb.test_name,
                 pid_i, exp_data, pdata_i);
        error_count_o++;
      end
      pending_o[pid_i] = 1'b0;
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      pending_o = '0;
      hold_q    = 1'b0;
    end else begin
      // A stalled response must stay put until it is taken
      if (hold_q) begin
        assert (pvalid_i && {pid_i, perror_i, pdata_i} == held_q) else begin
          $display("%s: response dropped or changed before it was accepted",
                   ipu_cluster_tb.test_name);
          error_count_o++;
        end
      end
      if (pvalid_i && pready_i) begin
        check_response();
      end
      if (qvalid_i && qready_i) begin
        pending_o[qid_i] = 1'b1;
        op_tab[qid_i]    = qop_i;
        a_tab[qid_i]     = qarga_i;
        b_tab[qid_i]     = qargb_i;
      end
      hold_q = pvalid_i && !pready_i;
      held_q = {pid_i, perror_i, pdata_i};
    end
  end

endmodule

// File: verif/ipu_cluster_tb.sv
`timescale 1ns/10ps

module ipu_cluster_tb import ipu_pkg::*; ();

  localparam int Timeout   = 1000;
  localparam int NumRandom = 200;

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic [IdWidth-1:0]    acc_qid_i;
  ipu_op_e               acc_qop_i;
  logic [DataWidth-1:0]  acc_qarga_i;
  logic [DataWidth-1:0]  acc_qargb_i;
  logic                  acc_qvalid_i;
  logic                  acc_qready_o;
  logic [DataWidth-1:0]  acc_pdata_o;
  logic [IdWidth-1:0]    acc_pid_o;
  logic                  acc_perror_o;
  logic                  acc_pvalid_o;
  logic                  acc_pready_i;

  logic [2**IdWidth-1:0] pending;
  int                    sb_errors;
  int                    resp_count;
  string                 test_name;
  int                    tb_errors;
  int                    err_mark;
  int                    tests_run;
  int                    tests_failed;
  logic [IdWidth-1:0]    next_id;
  int unsigned           rng_state   = 5;
  int unsigned           ready_state = 5;
  logic                  random_ready;
  logic [DataWidth-1:0]  corners [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                         32'h8000_0000, 32'h7fff_ffff, 32'hffff_fffd};

  always #5 clk_i = !clk_i;

  ipu_cluster ipu_cluster_inst (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .acc_qid_i    ( acc_qid_i    ),
    .acc_qop_i    ( acc_qop_i    ),
    .acc_qarga_i  ( acc_qarga_i  ),
    .acc_qargb_i  ( acc_qargb_i  ),
    .acc_qvalid_i ( acc_qvalid_i ),
    .acc_qready_o ( acc_qready_o ),
    .acc_pdata_o  ( acc_pdata_o  ),
    .acc_pid_o    ( acc_pid_o    ),
    .acc_perror_o ( acc_perror_o ),
    .acc_pvalid_o ( acc_pvalid_o ),
    .acc_pready_i ( acc_pready_i )
  );

  ipu_scoreboard scoreboard_inst (
    .clk_i         ( clk_i        ),
    .rst_i         ( rst_i        ),
    .qvalid_i      ( acc_qvalid_i ),
    .qready_i      ( acc_qready_o ),
    .qid_i         ( acc_qid_i    ),
    .qop_i         ( acc_qop_i    ),
    .qarga_i       ( acc_qarga_i  ),
    .qargb_i       ( acc_qargb_i  ),
    .pvalid_i      ( acc_pvalid_o ),
    .pready_i      ( acc_pready_i ),
    .pid_i         ( acc_pid_o    ),
    .perror_i      ( acc_perror_o ),
    .pdata_i       ( acc_pdata_o  ),
    .pending_o     ( pending      ),
    .error_count_o ( sb_errors    ),
    .resp_count_o  ( resp_count   )
  );

  // ------------------------------------------------------------
  // Random numbers
  // ------------------------------------------------------------
  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [DataWidth-1:0] rand_word();
    logic [15:0] hi;
    rng_state = lcg_step(rng_state);
    hi        = rng_state[31:16];
    rng_state = lcg_step(rng_state);
    return {hi, rng_state[31:16]};
  endfunction

  always @(negedge clk_i) begin
    if (random_ready) begin
      ready_state  = lcg_step(ready_state);
      acc_pready_i = ready_state[20];
    end
  end

  // ------------------------------------------------------------
  // Test bookkeeping and request driver
  // ------------------------------------------------------------
  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    tb_errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = tb_errors + sb_errors;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (pending != '0 && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    assert (pending == '0) else report_failure("responses still outstanding after timeout");
  endtask

  task automatic end_test();
    int n;
    wait_drain();
    n = tb_errors + sb_errors - err_mark;
    tests_run++;
    if (n == 0) begin
      $display("test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, n);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic send_request(input logic [2:0] op, input logic [DataWidth-1:0] a,
                              input logic [DataWidth-1:0] b);
    int t;
    t = 0;
    while (pending[next_id] && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    assert (!pending[next_id]) else report_failure("id stayed outstanding too long");
    acc_qid_i    = next_id;
    acc_qop_i    = ipu_op_e'(op);
    acc_qarga_i  = a;
    acc_qargb_i  = b;
    acc_qvalid_i = 1'b1;
    t = 0;
    while (!acc_qready_o && t < Timeout) begin
      @(negedge clk_i);
      t++;
    end
    assert (acc_qready_o) else report_failure("request was never accepted");
    @(negedge clk_i);
    acc_qvalid_i = 1'b0;
    next_id++;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int         lat;
    int         sent;
    logic [2:0] op_r;
    rst_i        = 1'b1;
    acc_qid_i    = '0;
    acc_qop_i    = OpMul;
    acc_qarga_i  = '0;
    acc_qargb_i  = '0;
    acc_qvalid_i = 1'b0;
    acc_pready_i = 1'b1;
    random_ready = 1'b0;
    next_id      = '0;

    start_test("reset");
    repeat (4) begin
      @(negedge clk_i);
      assert (!acc_pvalid_o) else report_failure("acc_pvalid_o high during reset");
    end
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!acc_pvalid_o) else report_failure("acc_pvalid_o high right after reset");
    assert (acc_qready_o) else report_failure("acc_qready_o low after reset");
    end_test();

    start_test("opcodes");
    for (int op = 0; op < 4; op++) begin
      foreach (corners[i]) begin
        foreach (corners[j]) begin
          send_request(3'(op), corners[i], corners[j]);
        end
      end
    end
    end_test();

    start_test("invalid_opcode");
    for (int op = 4; op < 8; op++) begin
      send_request(3'(op), rand_word(), rand_word());
      send_request(3'(op), 32'hffff_ffff, 32'h8000_0000);
    end
    end_test();

    // Request cycle counts as cycle 1, response expected in cycle 4
    start_test("latency");
    assert (acc_qready_o) else report_failure("acc_qready_o low on an idle cluster");
    send_request(3'(OpMulhu), 32'hdead_beef, 32'h0000_1234);
    lat = 1;
    while (!acc_pvalid_o && lat < Timeout) begin
      @(negedge clk_i);
      lat++;
    end
    assert (lat == 4) else begin
      $display("mismatch %s: expected %0d actual %0d", test_name, 4, lat);
      tb_errors++;
    end
    end_test();

    start_test("backpressure");
    acc_pready_i = 1'b0;
    sent = 0;
    while (acc_qready_o && sent < 2**IdWidth) begin
      send_request(3'(sent % 4), rand_word(), rand_word());
      sent++;
    end
    assert (!acc_qready_o) else report_failure("acc_qready_o never fell under back-pressure");
    acc_pready_i = 1'b1;
    end_test();

    start_test("random");
    random_ready = 1'b1;
    for (int n = 0; n < NumRandom; n++) begin
      rng_state = lcg_step(rng_state);
      op_r      = rng_state[20:18];
      send_request(op_r, rand_word(), rand_word());
    end
    end_test();
    random_ready = 1'b0;
    acc_pready_i = 1'b1;

    $display("tests %0d, failed %0d, responses %0d, errors %0d", tests_run, tests_failed,
             resp_count, tb_errors + sb_errors);
    if (tests_failed == 0 && tb_errors + sb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/ipu_pkg.sv
hdl/spill_register.sv
hdl/offload_dispatch.sv
hdl/ipu_lane.sv
hdl/offload_collect.sv
hdl/ipu_cluster.sv
verif/ipu_scoreboard.sv
verif/ipu_cluster_tb.sv
